/* src/isect_pkg.sv */
// Q16.16 types, pipeline latencies, register map and AXI response codes
`default_nettype none

package isect_pkg;

  // signed Q16.16
  typedef logic signed [31:0] fix_t;

  localparam int   FRAC_BITS = 16;
  localparam fix_t FIX_ONE   = 32'sh0001_0000;
  localparam fix_t FIX_MAX   = 32'sh7fff_ffff;
  localparam fix_t FIX_MIN   = 32'sh8000_0000;

  // one quotient bit per divider stage
  localparam int DIV_LAT = 32;
  // divider, then multiply, add and classify
  localparam int TUV_LAT = DIV_LAT + 3;

  localparam int ADDR_W = 8;
  // result count lives in STATUS[7:4]
  localparam int CNT_W  = 4;

  // ray fields that wait beside the divider
  typedef struct packed {
    fix_t ox;
    fix_t oy;
    fix_t dx;
    fix_t dy;
  } ray_xy_t;

  localparam logic [ADDR_W-1:0] REG_OX        = 8'h00;
  localparam logic [ADDR_W-1:0] REG_OY        = 8'h04;
  localparam logic [ADDR_W-1:0] REG_OZ        = 8'h08;
  localparam logic [ADDR_W-1:0] REG_DX        = 8'h0C;
  localparam logic [ADDR_W-1:0] REG_DY        = 8'h10;
  localparam logic [ADDR_W-1:0] REG_DZ        = 8'h14;
  localparam logic [ADDR_W-1:0] REG_CTRL      = 8'h18;
  localparam logic [ADDR_W-1:0] REG_STATUS    = 8'h1C;
  localparam logic [ADDR_W-1:0] REG_RES_T     = 8'h20;
  localparam logic [ADDR_W-1:0] REG_RES_U     = 8'h24;
  localparam logic [ADDR_W-1:0] REG_RES_V     = 8'h28;
  localparam logic [ADDR_W-1:0] REG_RES_FLAGS = 8'h2C;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* src/delay_line.sv */
// delay_line: fixed-latency shift pipeline with a parameterized payload type
`default_nettype none

module delay_line #(
  parameter int  LAT       = 1,
  parameter type payload_t = logic
) (
  input  wire           clk,
  input  wire           arst_n,
  input  wire payload_t d,
  output payload_t      q
);

  payload_t stage_q [LAT];

  // several items can be in flight, one per stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < LAT; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d;
      for (int i = 1; i < LAT; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign q = stage_q[LAT-1];

endmodule

`default_nettype wire

/* src/fix_div.sv */
// fix_div: pipelined signed Q16.16 restoring divider with saturation and divide-by-zero
`default_nettype none

module fix_div import isect_pkg::*; (
  input  wire       clk,
  input  wire       arst_n,
  input  wire fix_t num,
  input  wire fix_t den,
  output fix_t      quo,
  output logic      div_zero
);

  logic [31:0] mag_num;
  logic [31:0] mag_den;
  logic [31:0] rem_init;
  logic [31:0] dvd_init;
  logic [2:0]  flags_in;
  logic [2:0]  flags_q;
  logic        neg_q;
  logic        zero_q;
  logic        ovf_q;
  logic [32:0] step_c [DIV_LAT];
  logic [31:0] rem_q  [DIV_LAT];
  logic [31:0] dvd_q  [DIV_LAT];
  logic [31:0] den_q  [DIV_LAT];
  logic [31:0] quo_q  [DIV_LAT];

  // shift in one dividend bit, subtract when the divisor fits; returns {q_bit, rem}
  function automatic logic [32:0] div_step(logic [31:0] rem, logic bit_in, logic [31:0] dvs);
    logic [32:0] trial;
    trial = {rem, bit_in} - {1'b0, dvs};
    div_step = trial[32] ? {1'b0, rem[30:0], bit_in} : {1'b1, trial[31:0]};
  endfunction

  assign mag_num = num[31] ? -num : num;
  assign mag_den = den[31] ? -den : den;

  // dividend is num << FRAC_BITS; its upper word seeds the remainder
  assign rem_init = mag_num >> (32 - FRAC_BITS);
  assign dvd_init = mag_num << FRAC_BITS;

  // upper word >= divisor means the quotient needs more than 32 bits
  assign flags_in = {num[31] ^ den[31], den == '0, rem_init >= mag_den};

  always_comb begin
    step_c[0] = div_step(rem_init, dvd_init[31], mag_den);
    for (int i = 1; i < DIV_LAT; i++) begin
      step_c[i] = div_step(rem_q[i-1], dvd_q[i-1][31], den_q[i-1]);
    end
  end

  always_ff @(posedge clk) begin
    rem_q[0] <= step_c[0][31:0];
    dvd_q[0] <= {dvd_init[30:0], 1'b0};
    den_q[0] <= mag_den;
    quo_q[0] <= {31'b0, step_c[0][32]};
    for (int i = 1; i < DIV_LAT; i++) begin
      rem_q[i] <= step_c[i][31:0];
      dvd_q[i] <= {dvd_q[i-1][30:0], 1'b0};
      den_q[i] <= den_q[i-1];
      quo_q[i] <= {quo_q[i-1][30:0], step_c[i][32]};
    end
  end

  // sign, zero and overflow travel beside the quotient
  delay_line #(.LAT(DIV_LAT), .payload_t(logic [2:0])) i_flag_dly (
    .clk,
    .arst_n,
    .d (flags_in),
    .q (flags_q)
  );

  assign {neg_q, zero_q, ovf_q} = flags_q;
  assign div_zero = zero_q;

  // truncation toward zero, sign applied last
  always_comb begin
    if (zero_q) begin
      quo = '0;
    end else if (ovf_q || quo_q[DIV_LAT-1][31]) begin
      quo = neg_q ? FIX_MIN : FIX_MAX;
    end else if (neg_q) begin
      quo = -fix_t'(quo_q[DIV_LAT-1]);
    end else begin
      quo = fix_t'(quo_q[DIV_LAT-1]);
    end
  end

endmodule

`default_nettype wire

/* src/tuv_calc.sv */
// tuv_calc: execute stage computing t, u, v and the unit-triangle hit flag
`default_nettype none

module tuv_calc import isect_pkg::*; (
  input  wire       clk,
  input  wire       arst_n,
  input  wire       ray_valid,
  input  wire fix_t ray_ox,
  input  wire fix_t ray_oy,
  input  wire fix_t ray_oz,
  input  wire fix_t ray_dx,
  input  wire fix_t ray_dy,
  input  wire fix_t ray_dz,
  output logic      res_valid,
  output fix_t      res_t,
  output fix_t      res_u,
  output fix_t      res_v,
  output logic      res_hit,
  output logic      res_div_zero
);

  fix_t               neg_oz;
  fix_t               t_div;
  logic               dz_div;
  ray_xy_t            xy_in;
  ray_xy_t            xy_q;
  logic signed [63:0] prod_x;
  logic signed [63:0] prod_y;
  fix_t               mul_x;
  fix_t               mul_y;
  fix_t               ox_m;
  fix_t               oy_m;
  fix_t               u_a;
  fix_t               v_a;
  logic [32:0]        flag_q;
  fix_t               t_a;
  logic               dz_a;
  logic signed [32:0] uv_sum;

  // t = -oz / dz; -FIX_MIN wraps back to FIX_MIN
  assign neg_oz = -ray_oz;

  fix_div i_div (
    .clk,
    .arst_n,
    .num      (neg_oz),
    .den      (ray_dz),
    .quo      (t_div),
    .div_zero (dz_div)
  );

  assign xy_in = '{ox: ray_ox, oy: ray_oy, dx: ray_dx, dy: ray_dy};

  delay_line #(.LAT(DIV_LAT), .payload_t(ray_xy_t)) i_xy_dly (
    .clk,
    .arst_n,
    .d (xy_in),
    .q (xy_q)
  );

  delay_line #(.LAT(TUV_LAT), .payload_t(logic)) i_valid_dly (
    .clk,
    .arst_n,
    .d (ray_valid),
    .q (res_valid)
  );

  // t and div_zero ride along through the multiply and add stages
  delay_line #(.LAT(2), .payload_t(logic [32:0])) i_flag_dly (
    .clk,
    .arst_n,
    .d ({t_div, dz_div}),
    .q (flag_q)
  );

  assign {t_a, dz_a} = flag_q;

  // products are floored by the arithmetic drop of the fraction
  assign prod_x = t_div * xy_q.dx;
  assign prod_y = t_div * xy_q.dy;

  always_ff @(posedge clk) begin
    mul_x <= prod_x[FRAC_BITS +: 32];
    mul_y <= prod_y[FRAC_BITS +: 32];
    ox_m  <= xy_q.ox;
    oy_m  <= xy_q.oy;
  end

  // u and v wrap at 32 bits
  always_ff @(posedge clk) begin
    u_a <= mul_x + ox_m;
    v_a <= mul_y + oy_m;
  end

  // one extra bit so u + v cannot wrap below one
  assign uv_sum = {u_a[31], u_a} + {v_a[31], v_a};

  always_ff @(posedge clk) begin
    res_t        <= t_a;
    res_u        <= u_a;
    res_v        <= v_a;
    res_div_zero <= dz_a;
    res_hit      <= !dz_a && (t_a > 0) && (u_a > 0) && (v_a > 0) &&
                    (uv_sum < $signed({1'b0, FIX_ONE}));
  end

  a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(res_valid));

endmodule

`default_nettype wire

/* src/axil_reg_decode.sv */
// axil_reg_decode: AXI4-Lite slave, ray registers, start issue and result read mux
`default_nettype none

module axil_reg_decode import isect_pkg::*; (
  input  wire              clk,
  input  wire              arst_n,
  input  wire [ADDR_W-1:0] s_axil_awaddr,
  input  wire              s_axil_awvalid,
  output logic             s_axil_awready,
  input  wire [31:0]       s_axil_wdata,
  input  wire [3:0]        s_axil_wstrb,
  input  wire              s_axil_wvalid,
  output logic             s_axil_wready,
  output logic [1:0]       s_axil_bresp,
  output logic             s_axil_bvalid,
  input  wire              s_axil_bready,
  input  wire [ADDR_W-1:0] s_axil_araddr,
  input  wire              s_axil_arvalid,
  output logic             s_axil_arready,
  output logic [31:0]      s_axil_rdata,
  output logic [1:0]       s_axil_rresp,
  output logic             s_axil_rvalid,
  input  wire              s_axil_rready,
  input  wire              issue_ok,
  input  wire              res_avail,
  input  wire [CNT_W-1:0]  res_count,
  input  wire fix_t        head_t,
  input  wire fix_t        head_u,
  input  wire fix_t        head_v,
  input  wire              head_hit,
  input  wire              head_div_zero,
  output logic             ray_valid,
  output fix_t             ray_ox,
  output fix_t             ray_oy,
  output fix_t             ray_oz,
  output fix_t             ray_dx,
  output fix_t             ray_dy,
  output fix_t             ray_dz,
  output logic             issue,
  output logic             pop
);

  logic        wr_hs;
  logic        rd_hs;
  logic        start_req;
  logic [1:0]  wr_resp;
  logic [31:0] rd_data;
  logic [1:0]  rd_resp;
  logic        res_sel;

  // s_axil_wstrb is not decoded, every register takes whole words
  assign wr_hs          = s_axil_awready && s_axil_awvalid && s_axil_wvalid;
  assign rd_hs          = s_axil_arready && s_axil_arvalid;
  assign s_axil_wready  = s_axil_awready;
  assign s_axil_arready = !s_axil_rvalid;
  // the accepted start feeds both the pipeline and the credit counter
  assign ray_valid      = issue;

  always_comb begin
    start_req = 1'b0;
    wr_resp   = RESP_OKAY;
    case (s_axil_awaddr)
      REG_OX, REG_OY, REG_OZ, REG_DX, REG_DY, REG_DZ: wr_resp = RESP_OKAY;
      REG_CTRL: begin
        start_req = s_axil_wdata[0] && issue_ok;
        // no free result slot
        if (s_axil_wdata[0] && !issue_ok) begin
          wr_resp = RESP_SLVERR;
        end
      end
      default: wr_resp = RESP_SLVERR;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s_axil_awready <= 1'b0;
      s_axil_bvalid  <= 1'b0;
      issue          <= 1'b0;
    end else begin
      s_axil_awready <= s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid && !s_axil_awready;
      issue          <= wr_hs && start_req;
      if (wr_hs) begin
        s_axil_bvalid <= 1'b1;
      end else if (s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      s_axil_bresp <= wr_resp;
      case (s_axil_awaddr)
        REG_OX:  ray_ox <= s_axil_wdata;
        REG_OY:  ray_oy <= s_axil_wdata;
        REG_OZ:  ray_oz <= s_axil_wdata;
        REG_DX:  ray_dx <= s_axil_wdata;
        REG_DY:  ray_dy <= s_axil_wdata;
        REG_DZ:  ray_dz <= s_axil_wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    res_sel = 1'b0;
    case (s_axil_araddr)
      REG_OX:        rd_data = ray_ox;
      REG_OY:        rd_data = ray_oy;
      REG_OZ:        rd_data = ray_oz;
      REG_DX:        rd_data = ray_dx;
      REG_DY:        rd_data = ray_dy;
      REG_DZ:        rd_data = ray_dz;
      REG_CTRL:      rd_data = '0;
      REG_STATUS:    rd_data = {24'b0, res_count, 3'b0, res_avail};
      REG_RES_T:     {res_sel, rd_data} = {1'b1, head_t};
      REG_RES_U:     {res_sel, rd_data} = {1'b1, head_u};
      REG_RES_V:     {res_sel, rd_data} = {1'b1, head_v};
      REG_RES_FLAGS: {res_sel, rd_data} = {1'b1, 30'b0, head_div_zero, head_hit};
      default:       rd_resp = RESP_SLVERR;
    endcase
    // result words need a queued entry
    if (res_sel && !res_avail) begin
      rd_data = '0;
      rd_resp = RESP_SLVERR;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s_axil_rvalid <= 1'b0;
      pop           <= 1'b0;
    end else begin
      pop <= rd_hs && (s_axil_araddr == REG_RES_FLAGS) && res_avail;
      if (rd_hs) begin
        s_axil_rvalid <= 1'b1;
      end else if (s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs) begin
      s_axil_rdata <= rd_data;
      s_axil_rresp <= rd_resp;
    end
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp));

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

`default_nettype wire

/* src/result_store.sv */
// result_store: in-order result queue, issue credit counter and status outputs
`default_nettype none

module result_store import isect_pkg::*; #(
  // must stay below 2**CNT_W
  parameter int RES_DEPTH = 4
) (
  input  wire             clk,
  input  wire             arst_n,
  input  wire             res_valid,
  input  wire fix_t       res_t,
  input  wire fix_t       res_u,
  input  wire fix_t       res_v,
  input  wire             res_hit,
  input  wire             res_div_zero,
  input  wire             issue,
  input  wire             pop,
  output logic            issue_ok,
  output logic            res_avail,
  output logic [CNT_W-1:0] res_count,
  output fix_t            head_t,
  output fix_t            head_u,
  output fix_t            head_v,
  output logic            head_hit,
  output logic            head_div_zero
);

  localparam int PTR_W = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;

  typedef struct packed {
    fix_t t;
    fix_t u;
    fix_t v;
    logic hit;
    logic div_zero;
  } entry_t;

  entry_t           mem [RES_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  // slots reserved by rays in flight plus slots occupied
  logic [CNT_W-1:0] credits;

  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
    ptr_inc = (p == PTR_W'(RES_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (res_valid) begin
      mem[wr_ptr] <= '{t: res_t, u: res_u, v: res_v, hit: res_hit, div_zero: res_div_zero};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= '0;
    end else begin
      if (res_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count   <= count + CNT_W'(res_valid) - CNT_W'(pop);
      credits <= credits + CNT_W'(issue) - CNT_W'(pop);
    end
  end

  assign issue_ok      = credits < CNT_W'(RES_DEPTH);
  assign res_avail     = count != '0;
  assign res_count     = count;
  assign head_t        = mem[rd_ptr].t;
  assign head_u        = mem[rd_ptr].u;
  assign head_v        = mem[rd_ptr].v;
  assign head_hit      = mem[rd_ptr].hit;
  assign head_div_zero = mem[rd_ptr].div_zero;

  // credits taken at issue guarantee a slot when the pipeline delivers
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    res_valid |-> count < CNT_W'(RES_DEPTH));

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    pop |-> count != '0);

endmodule

`default_nettype wire

/* src/isect_unit.sv */
// isect_unit: top level joining register decode, t/u/v pipeline and result queue
`default_nettype none

module isect_unit import isect_pkg::*; #(
  parameter int RES_DEPTH = 4
) (
  input  wire              clk,
  input  wire              arst_n,
  input  wire [ADDR_W-1:0] s_axil_awaddr,
  input  wire              s_axil_awvalid,
  output logic             s_axil_awready,
  input  wire [31:0]       s_axil_wdata,
  input  wire [3:0]        s_axil_wstrb,
  input  wire              s_axil_wvalid,
  output logic             s_axil_wready,
  output logic [1:0]       s_axil_bresp,
  output logic             s_axil_bvalid,
  input  wire              s_axil_bready,
  input  wire [ADDR_W-1:0] s_axil_araddr,
  input  wire              s_axil_arvalid,
  output logic             s_axil_arready,
  output logic [31:0]      s_axil_rdata,
  output logic [1:0]       s_axil_rresp,
  output logic             s_axil_rvalid,
  input  wire              s_axil_rready
);

  // decode to execute
  logic             ray_valid;
  fix_t             ray_ox;
  fix_t             ray_oy;
  fix_t             ray_oz;
  fix_t             ray_dx;
  fix_t             ray_dy;
  fix_t             ray_dz;

  // execute to result
  logic             res_valid;
  fix_t             res_t;
  fix_t             res_u;
  fix_t             res_v;
  logic             res_hit;
  logic             res_div_zero;

  // result queue and decode
  logic             issue;
  logic             pop;
  logic             issue_ok;
  logic             res_avail;
  logic [CNT_W-1:0] res_count;
  fix_t             head_t;
  fix_t             head_u;
  fix_t             head_v;
  logic             head_hit;
  logic             head_div_zero;

  axil_reg_decode i_decode (.*);

  tuv_calc i_execute (.*);

  result_store #(.RES_DEPTH(RES_DEPTH)) i_result (.*);

endmodule

`default_nettype wire

/* verification/tb_axil_tasks.svh */
// AXI4-Lite write and read tasks, response stall lengths and an xorshift32 generator
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// xorshift32 step on the shared generator state
function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// cycles that a ready stays low once a response is up
function automatic int unsigned stall_len();
  if (!stall_en) begin
    return 0;
  end
  return next_rand() % 8;
endfunction

task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
  int unsigned hold;
  int unsigned aw_beats;
  @(negedge clk);
  s_axil_awaddr  = addr;
  s_axil_awvalid = 1'b1;
  s_axil_wdata   = data;
  s_axil_wvalid  = 1'b1;
  aw_beats       = 0;
  // awready pulses, then bvalid follows one edge later
  do begin
    @(negedge clk);
    assert (s_axil_wready === s_axil_awready) else begin
      $display("%0t: wready and awready disagree on the write to 0x%02h", $time, addr);
      proto_errs++;
    end
    if (s_axil_awready) begin
      aw_beats++;
    end
  end while (!s_axil_bvalid);
  s_axil_awvalid = 1'b0;
  s_axil_wvalid  = 1'b0;
  // one address and data beat per write
  assert (aw_beats == 1) else begin
    $display("%0t: write to 0x%02h saw awready high for %0d cycles instead of one",
             $time, addr, aw_beats);
    proto_errs++;
  end
  hold = stall_len();
  repeat (hold) @(negedge clk);
  assert (s_axil_bvalid) else begin
    $display("%0t: write response to 0x%02h dropped while bready was low", $time, addr);
    proto_errs++;
  end
  resp = s_axil_bresp;
  s_axil_bready = 1'b1;
  @(negedge clk);
  s_axil_bready = 1'b0;
  // exactly one response per write
  assert (!s_axil_bvalid) else begin
    $display("%0t: write response to 0x%02h still pending after bready", $time, addr);
    proto_errs++;
  end
endtask

task automatic axil_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
  int unsigned hold;
  @(negedge clk);
  assert (s_axil_arready) else begin
    $display("%0t: arready low before the read from 0x%02h with no response pending",
             $time, addr);
    proto_errs++;
  end
  s_axil_araddr  = addr;
  s_axil_arvalid = 1'b1;
  // arready is high while no read response waits
  do begin
    @(negedge clk);
  end while (!s_axil_rvalid);
  s_axil_arvalid = 0;
  hold = stall_len();
  repeat (hold) @(negedge clk);
  assert (s_axil_rvalid) else begin
    $display("%0t: read response from 0x%02h dropped while rready was low", $time, addr);
    proto_errs++;
  end
  // a pending response blocks the next address
  assert (!s_axil_arready) else begin
    $display("%0t: arready high while the read response from 0x%02h was pending",
             $time, addr);
    proto_errs++;
  end
  data = s_axil_rdata;
  resp = s_axil_rresp;
  s_axil_rready = 1'b1;
  @(negedge clk);
  s_axil_rready = 1'b0;
  assert (!s_axil_rvalid) else begin
    $display("%0t: read response from 0x%02h still pending after rready", $time, addr);
    proto_errs++;
  end
endtask

`endif

/* verification/tb_isect_unit.sv */
// testbench for isect_unit: clock, reset, reference model, tests, result checker, watchdog
`default_nettype none

module tb_isect_unit import isect_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RAND_RAYS  = 200;
  localparam int STALL_RAYS = 16;
  localparam int N_RAYS     = 4 + RAND_RAYS + 5 + STALL_RAYS;
  // about twenty bus transfers per ray, plus the register tests
  localparam int N_OPS      = N_RAYS * 20 + 40;
  localparam int POLL_MAX   = 4 * TUV_LAT;

  typedef struct packed {
    fix_t        t;
    fix_t        u;
    fix_t        v;
    logic [31:0] flags;
  } exp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [31:0]       data;
    logic [1:0]        resp;
  } obs_t;

  logic              clk;
  logic              arst_n;
  logic [ADDR_W-1:0] s_axil_awaddr;
  logic              s_axil_awvalid;
  logic              s_axil_awready;
  logic [31:0]       s_axil_wdata;
  logic [3:0]        s_axil_wstrb;
  logic              s_axil_wvalid;
  logic              s_axil_wready;
  logic [1:0]        s_axil_bresp;
  logic              s_axil_bvalid;
  logic              s_axil_bready;
  logic [ADDR_W-1:0] s_axil_araddr;
  logic              s_axil_arvalid;
  logic              s_axil_arready;
  logic [31:0]       s_axil_rdata;
  logic [1:0]        s_axil_rresp;
  logic              s_axil_rvalid;
  logic              s_axil_rready;

  logic [31:0] rng_state  = 32'd16;
  bit          stall_en   = 1'b0;
  int unsigned val_errs   = 0;
  int unsigned resp_errs  = 0;
  int unsigned proto_errs = 0;
  fix_t        ray_regs [6];
  exp_t        exp_q [$];
  obs_t        obs_q [$];

  `include "tb_axil_tasks.svh"

  isect_unit #(.RES_DEPTH(4)) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // t = -oz / dz truncated and saturated, floored products, wrapping u and v
  function automatic exp_t ref_tuv(input fix_t ox, input fix_t oy, input fix_t oz,
                                   input fix_t dx, input fix_t dy, input fix_t dz);
    exp_t   r;
    fix_t   neg_oz;
    longint quo;
    longint px;
    longint py;
    logic   hit;
    neg_oz = -oz;
    quo    = 0;
    if (dz != 0) begin
      quo = (longint'(neg_oz) * 65536) / longint'(dz);
      if (quo > longint'(FIX_MAX)) begin
        quo = longint'(FIX_MAX);
      end else if (quo < longint'(FIX_MIN)) begin
        quo = longint'(FIX_MIN);
      end
    end
    r.t = fix_t'(quo);
    px  = longint'(r.t) * longint'(dx);
    py  = longint'(r.t) * longint'(dy);
    r.u = fix_t'(px >>> 16) + ox;
    r.v = fix_t'(py >>> 16) + oy;
    hit = (dz != 0) && (r.t > 0) && (r.u > 0) && (r.v > 0) &&
          (longint'(r.u) + longint'(r.v) < 65536);
    r.flags = {30'b0, dz == 0, hit};
    return r;
  endfunction

  // uniform over [-span/2, span/2)
  function automatic fix_t rand_fix(input logic [31:0] span);
    return fix_t'(next_rand() % span) - fix_t'(span >> 1);
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
      val_errs++;
    end
  endtask

  task automatic check_resp(input logic [ADDR_W-1:0] addr, input logic [1:0] got,
                            input logic [1:0] exp);
    assert (got === exp) else begin
      $display("%0t: address 0x%02h answered with response %0d instead of %0d",
               $time, addr, got, exp);
      resp_errs++;
    end
  endtask

  task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(addr, data, resp);
    check_resp(addr, resp, exp_resp);
    if (exp_resp == RESP_OKAY) begin
      check_value($sformatf("register 0x%02h", addr), data, exp_data);
    end
  endtask

  task automatic load_ray(input fix_t ox, input fix_t oy, input fix_t oz,
                          input fix_t dx, input fix_t dy, input fix_t dz);
    logic [1:0] resp;
    ray_regs = '{ox, oy, oz, dx, dy, dz};
    for (int i = 0; i < 6; i++) begin
      axil_write(ADDR_W'(4 * i), ray_regs[i], resp);
      check_resp(ADDR_W'(4 * i), resp, RESP_OKAY);
    end
  endtask

  task automatic start_ray(input logic [1:0] exp_resp);
    logic [1:0] resp;
    axil_write(REG_CTRL, 32'h1, resp);
    check_resp(REG_CTRL, resp, exp_resp);
    if (exp_resp == RESP_OKAY) begin
      exp_q.push_back(ref_tuv(ray_regs[0], ray_regs[1], ray_regs[2],
                              ray_regs[3], ray_regs[4], ray_regs[5]));
    end
  endtask

  // poll STATUS until the result count reaches n
  task automatic wait_results(input int unsigned n);
    logic [31:0] data;
    logic [1:0]  resp;
    int          polls;
    polls = 0;
    do begin
      axil_read(REG_STATUS, data, resp);
      polls++;
    end while (data[7:4] < n && polls < POLL_MAX);
    assert (data[7:4] >= n) else begin
      $display("%0t: result count stuck at %0d while waiting for %0d", $time, data[7:4], n);
      proto_errs++;
    end
  endtask

  // head entry goes to the compare process, FLAGS last since it pops
  task automatic read_result();
    logic [ADDR_W-1:0] addr;
    logic [31:0]       data;
    logic [1:0]        resp;
    for (int i = 0; i < 4; i++) begin
      addr = REG_RES_T + ADDR_W'(4 * i);
      axil_read(addr, data, resp);
      obs_q.push_back('{addr: addr, data: data, resp: resp});
    end
  endtask

  task automatic run_ray(input fix_t ox, input fix_t oy, input fix_t oz,
                         input fix_t dx, input fix_t dy, input fix_t dz);
    load_ray(ox, oy, oz, dx, dy, dz);
    start_ray(RESP_OKAY);
    wait_results(1);
    read_result();
  endtask

  task automatic run_random_ray(input bit full_range, input bit zero_dz);
    fix_t r [6];
    if (full_range) begin
      for (int k = 0; k < 6; k++) begin
        r[k] = fix_t'(next_rand());
      end
    end else begin
      // origins around the triangle, so hits and misses both show up
      r[0] = rand_fix(32'h0002_0000) + 32'sh8000;
      r[1] = rand_fix(32'h0002_0000) + 32'sh8000;
      r[2] = rand_fix(32'h0008_0000);
      r[3] = rand_fix(32'h0004_0000);
      r[4] = rand_fix(32'h0004_0000);
      r[5] = rand_fix(32'h0004_0000);
    end
    if (zero_dz) begin
      r[5] = '0;
    end
    run_ray(r[0], r[1], r[2], r[3], r[4], r[5]);
  endtask

  task automatic print_counts();
    $display("error counts: value %0d, response %0d, protocol %0d",
             val_errs, resp_errs, proto_errs);
  endtask

  initial begin : compare
    obs_t o;
    exp_t e;
    forever begin
      @(negedge clk);
      while (obs_q.size() != 0) begin
        o = obs_q.pop_front();
        check_resp(o.addr, o.resp, RESP_OKAY);
        assert (exp_q.size() != 0) else begin
          $display("%0t: result read from 0x%02h with no ray outstanding", $time, o.addr);
          proto_errs++;
        end
        if (exp_q.size() != 0) begin
          e = exp_q[0];
          case (o.addr)
            REG_RES_T: check_value("t", o.data, e.t);
            REG_RES_U: check_value("u", o.data, e.u);
            REG_RES_V: check_value("v", o.data, e.v);
            default: begin
              check_value("flags", o.data, e.flags);
              e = exp_q.pop_front();
            end
          endcase
        end
      end
    end
  end

  initial begin : watchdog
    repeat (N_OPS * 100) @(posedge clk);
    $display("watchdog expired after %0d cycles before the tests completed", N_OPS * 100);
    print_counts();
    $display("Done: errors found");
    $finish;
  end

  initial begin : main
    logic [1:0]  resp;
    logic [31:0] wr_vals [6];
    arst_n         = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = 4'hF;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    repeat (16) @(negedge clk);
    arst_n = 1'b1;

    // idle status and ray register readback
    read_check(REG_STATUS, 32'h0, RESP_OKAY);
    for (int i = 0; i < 6; i++) begin
      wr_vals[i] = next_rand();
      axil_write(ADDR_W'(4 * i), wr_vals[i], resp);
      check_resp(ADDR_W'(4 * i), resp, RESP_OKAY);
    end
    for (int i = 0; i < 6; i++) begin
      read_check(ADDR_W'(4 * i), wr_vals[i], RESP_OKAY);
    end

    // directed: hit at u = v = 0.25, u + v over one, t below zero, dz = 0
    run_ray(32'sh8000, 32'sh0, 32'sh2_0000, -32'sh2000, 32'sh2000, -32'sh1_0000);
    run_ray(32'shC000, 32'shC000, 32'sh1_0000, 32'sh0, 32'sh0, -32'sh1_0000);
    run_ray(32'sh4000, 32'sh4000, 32'sh1_0000, 32'sh0, 32'sh0, 32'sh1_0000);
    run_ray(32'sh4000, 32'sh4000, 32'sh1_0000, 32'sh8000, 32'sh8000, 32'sh0);

    for (int i = 0; i < RAND_RAYS; i++) begin
      run_random_ray(i % 16 == 15, i % 20 == 7);
    end

    // four rays in flight fill every credit
    for (int i = 0; i < 4; i++) begin
      load_ray(fix_t'(i * 32'sh2000), 32'sh4000, 32'sh1_0000, 32'sh1000, 32'sh0,
               (i == 2) ? 32'sh1_0000 : -32'sh1_0000);
      start_ray(RESP_OKAY);
    end
    start_ray(RESP_SLVERR);
    wait_results(4);
    read_check(REG_STATUS, 32'h41, RESP_OKAY);
    repeat (4) read_result();
    read_check(REG_STATUS, 32'h0, RESP_OKAY);

    // error responses leave the queue alone
    axil_write(8'h40, 32'h1, resp);
    check_resp(8'h40, resp, RESP_SLVERR);
    read_check(8'h44, 32'h0, RESP_SLVERR);
    read_check(REG_RES_FLAGS, 32'h0, RESP_SLVERR);
    read_check(REG_RES_T, 32'h0, RESP_SLVERR);
    read_check(REG_STATUS, 32'h0, RESP_OKAY);

    // random bready and rready stalls
    stall_en = 1'b1;
    for (int i = 0; i < STALL_RAYS; i++) begin
      run_random_ray(1'b0, i == 5);
    end
    read_check(REG_STATUS, 32'h0, RESP_OKAY);
    stall_en = 1'b0;

    repeat (2) @(negedge clk);
    assert (exp_q.size() == 0) else begin
      $display("%0t: %0d expected results were never read back", $time, exp_q.size());
      proto_errs++;
    end
    print_counts();
    if (val_errs + resp_errs + proto_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verification
src/isect_pkg.sv
src/delay_line.sv
src/fix_div.sv
src/tuv_calc.sv
src/axil_reg_decode.sv
src/result_store.sv
src/isect_unit.sv
verification/tb_isect_unit.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_isect_unit -f sim.f -o tb_isect_unit
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_isect_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  exit 1
fi
if ! grep -q "Done: no errors" "$LOG"; then
  echo "simulation log has no result line"
  exit 1
fi
exit 0
